// File: verilog/mister_cfg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame configuration types: status word layout, register map and
// the Wishbone classic request/response bundles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mister_cfg_pkg;

// Host bus widths
localparam int WB_ADR_W = 4;
localparam int WB_DAT_W = 32;

// Status word fields
// bits 17 and 18 turn the two DB15 ports on, the rest are left to the core
localparam int STATUS_DB15_EN1_BIT = 17;
localparam int STATUS_DB15_EN2_BIT = 18;

// Word addresses seen by the host
typedef enum logic [WB_ADR_W-1:0] {
    CFG_STATUS = 4'd0,
    CFG_DIPSW  = 4'd1
} cfg_reg_e;

// Master to slave
typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
} wb_req_t;

// Slave to master
typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
} wb_rsp_t;

// Decoded status fields
typedef struct packed {
    logic db15_en1;
    logic db15_en2;
} cfg_fields_t;

endpackage

// File: verilog/mister_io_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joystick words and DDR burst-port request types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mister_io_pkg;

// Joystick widths
localparam int JOY_W  = 16;
localparam int DB15_W = 12;

// DDR port widths
localparam int DDR_ADDR_W  = 29;
localparam int DDR_BURST_W = 8;
localparam int DDR_BE_W    = 8;

typedef logic [JOY_W-1:0]  joy_word_t;
typedef logic [DB15_W-1:0] db15_word_t;

// Fast ROM loader, read only
typedef struct packed {
    logic [DDR_BURST_W-1:0] burstcnt;
    logic [DDR_ADDR_W-1:0]  addr;
    logic                   rd;
} ddr_load_req_t;

// Screen rotator, reads and writes
typedef struct packed {
    logic [DDR_BURST_W-1:0] burstcnt;
    logic [DDR_ADDR_W-1:0]  addr;
    logic                   rd;
    logic                   we;
    logic [DDR_BE_W-1:0]    be;
} ddr_rot_req_t;

// Command toward the DDR port
typedef struct packed {
    logic [DDR_BURST_W-1:0] burstcnt;
    logic [DDR_ADDR_W-1:0]  addr;
    logic                   rd;
    logic                   we;
    logic [DDR_BE_W-1:0]    be;
} ddr_cmd_t;

typedef enum logic [1:0] {
    OWN_ROT,
    OWN_LOAD,
    DRAIN_TO_ROT,
    DRAIN_TO_LOAD
} ddr_owner_e;

endpackage

// File: verilog/mister_cfg_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave for the status and DIP switch words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mister_cfg_regs import mister_cfg_pkg::*; (
    input  logic                clk_rom,
    input  logic                rst,
    input  wb_req_t             wb_req,
    output wb_rsp_t             wb_rsp,
    output logic [WB_DAT_W-1:0] status,
    output logic [WB_DAT_W-1:0] dipsw,
    output cfg_fields_t         cfg
);

logic                req_new;
logic                ack_q;
logic [WB_DAT_W-1:0] rd_mux;
logic [WB_DAT_W-1:0] rdat_q;
cfg_reg_e            reg_sel;

// A request is served once, then ack drops for a cycle
assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;
assign reg_sel = cfg_reg_e'(wb_req.adr);

// Unmapped addresses read as zero
always_comb begin
    case (reg_sel)
        CFG_STATUS: rd_mux = status;
        CFG_DIPSW:  rd_mux = dipsw;
        default:    rd_mux = '0;
    endcase
end

always_ff @(posedge clk_rom) begin
    if (rst) begin
        ack_q  <= 1'b0;
        status <= '0;
        dipsw  <= '0;
        cfg    <= '0;
    end else begin
        ack_q <= req_new;
        // Write lands on the edge that raises ack
        if (req_new && wb_req.we) begin
            case (reg_sel)
                CFG_STATUS: status <= wb_req.dat;
                CFG_DIPSW:  dipsw  <= wb_req.dat;
                default:    ;
            endcase
        end
        // Fields follow status one cycle later
        cfg.db15_en1 <= status[STATUS_DB15_EN1_BIT];
        cfg.db15_en2 <= status[STATUS_DB15_EN2_BIT];
    end
end

// Read data, only meaningful while ack is high
always_ff @(posedge clk_rom) begin
    if (req_new) begin
        rdat_q <= rd_mux;
    end
end

assign wb_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

// File: verilog/mister_joy_router.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joystick router, merges DB15 and USB pads into four player words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mister_joy_router import mister_cfg_pkg::*, mister_io_pkg::*; #(
    parameter int BUTTONS = 2
) (
    input  logic        clk_rom,
    input  logic        rst,
    input  cfg_fields_t cfg,
    input  db15_word_t  db15_1,
    input  db15_word_t  db15_2,
    input  joy_word_t   usb_1,
    input  joy_word_t   usb_2,
    input  joy_word_t   usb_3,
    input  joy_word_t   usb_4,
    output joy_word_t   player_1,
    output joy_word_t   player_2,
    output joy_word_t   player_3,
    output joy_word_t   player_4
);

joy_word_t db_1;
joy_word_t db_2;
joy_word_t nx_1;
joy_word_t nx_2;
joy_word_t nx_3;
joy_word_t nx_4;

// Directions and buttons stay, then start and coin on top
// start + button 2 also gives a coin
function automatic joy_word_t db15_remap(input db15_word_t raw);
    joy_word_t w;
    w                = '0;
    w[3+BUTTONS:0]   = raw[3+BUTTONS:0];
    w[4+BUTTONS]     = raw[10];
    w[5+BUTTONS]     = raw[11] | (raw[10] & raw[5]);
    return w;
endfunction

assign db_1 = db15_remap(db15_1);
assign db_2 = db15_remap(db15_2);

// USB pads shift up by the number of DB15 ports in use
always_comb begin
    nx_1 = cfg.db15_en1 ? db_1 : usb_1;

    if (cfg.db15_en2) begin
        nx_2 = db_2;
    end else begin
        nx_2 = cfg.db15_en1 ? usb_1 : usb_2;
    end

    if (cfg.db15_en1) begin
        nx_3 = usb_1;
        nx_4 = usb_2;
    end else if (cfg.db15_en2) begin
        nx_3 = usb_2;
        nx_4 = usb_3;
    end else begin
        nx_3 = usb_3;
        nx_4 = usb_4;
    end
end

always_ff @(posedge clk_rom) begin
    if (rst) begin
        player_1 <= '0;
        player_2 <= '0;
        player_3 <= '0;
        player_4 <= '0;
    end else begin
        player_1 <= nx_1;
        player_2 <= nx_2;
        player_3 <= nx_3;
        player_4 <= nx_4;
    end
end

endmodule

// File: verilog/mister_ddr_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR burst-port arbiter, ROM loader vs screen rotator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mister_ddr_arbiter import mister_io_pkg::*; (
    input  logic          clk_rom,
    input  logic          rst,
    input  logic          downloading,
    input  ddr_load_req_t load_req,
    output logic          load_busy,
    input  ddr_rot_req_t  rot_req,
    output logic          rot_busy,
    output ddr_cmd_t      ddr_cmd,
    input  logic          ddr_busy,
    input  logic          ddr_dout_ready
);

// Room for a few full bursts in flight
localparam int CNT_W = DDR_BURST_W + 2;

ddr_owner_e       state_q;
ddr_owner_e       state_nx;
logic [CNT_W-1:0] pending_q;
logic [CNT_W-1:0] add_beats;
logic [CNT_W-1:0] sub_beats;
logic             pending_zero;
logic             rd_accept;
logic             beat_in;

assign pending_zero = (pending_q == '0);
assign rd_accept    = ddr_cmd.rd & ~ddr_busy;
assign beat_in      = ddr_dout_ready & ~pending_zero;

assign add_beats = rd_accept ? CNT_W'(ddr_cmd.burstcnt) : '0;
assign sub_beats = {{(CNT_W-1){1'b0}}, beat_in};

// Owner's request goes straight through, nothing while draining
always_comb begin
    ddr_cmd = '0;
    case (state_q)
        OWN_ROT: begin
            ddr_cmd.burstcnt = rot_req.burstcnt;
            ddr_cmd.addr     = rot_req.addr;
            ddr_cmd.rd       = rot_req.rd;
            ddr_cmd.we       = rot_req.we;
            ddr_cmd.be       = rot_req.be;
        end
        OWN_LOAD: begin
            // loader never writes, we and be stay zero
            ddr_cmd.burstcnt = load_req.burstcnt;
            ddr_cmd.addr     = load_req.addr;
            ddr_cmd.rd       = load_req.rd;
        end
        default: ;
    endcase
end

// Hand over only once all read beats are back
always_comb begin
    state_nx = state_q;
    case (state_q)
        OWN_ROT: begin
            if (downloading) begin
                state_nx = DRAIN_TO_LOAD;
            end
        end
        DRAIN_TO_LOAD: begin
            if (pending_zero) begin
                state_nx = OWN_LOAD;
            end
        end
        OWN_LOAD: begin
            if (!downloading) begin
                state_nx = DRAIN_TO_ROT;
            end
        end
        DRAIN_TO_ROT: begin
            if (pending_zero) begin
                state_nx = OWN_ROT;
            end
        end
        default: state_nx = OWN_ROT;
    endcase
end

always_ff @(posedge clk_rom) begin
    if (rst) begin
        state_q   <= OWN_ROT;
        pending_q <= '0;
    end else begin
        state_q   <= state_nx;
        pending_q <= pending_q + add_beats - sub_beats;
    end
end

// DDR back-pressure reaches the owner unchanged
assign rot_busy  = (state_q != OWN_ROT)  | ddr_busy;
assign load_busy = (state_q != OWN_LOAD) | ddr_busy;

endmodule

// File: verilog/mister_frame.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame wrapper top: configuration, joystick routing, DDR arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mister_frame import mister_cfg_pkg::*, mister_io_pkg::*; #(
    parameter int BUTTONS = 2
) (
    input  logic                clk_rom,
    input  logic                rst,
    // Host
    input  wb_req_t             wb_req,
    output wb_rsp_t             wb_rsp,
    output logic [WB_DAT_W-1:0] status,
    output logic [WB_DAT_W-1:0] dipsw,
    // Joysticks
    input  db15_word_t          db15_1,
    input  db15_word_t          db15_2,
    input  joy_word_t           usb_1,
    input  joy_word_t           usb_2,
    input  joy_word_t           usb_3,
    input  joy_word_t           usb_4,
    output joy_word_t           player_1,
    output joy_word_t           player_2,
    output joy_word_t           player_3,
    output joy_word_t           player_4,
    // DDR requesters and port
    input  logic                downloading,
    input  ddr_load_req_t       load_req,
    output logic                load_busy,
    input  ddr_rot_req_t        rot_req,
    output logic                rot_busy,
    output ddr_cmd_t            ddr_cmd,
    input  logic                ddr_busy,
    input  logic                ddr_dout_ready
);

cfg_fields_t cfg;

mister_cfg_regs u_cfg_regs (
    .clk_rom    ( clk_rom   ),
    .rst        ( rst       ),
    .wb_req     ( wb_req    ),
    .wb_rsp     ( wb_rsp    ),
    .status     ( status    ),
    .dipsw      ( dipsw     ),
    .cfg        ( cfg       )
);

mister_joy_router #(
    .BUTTONS    ( BUTTONS   )
) u_joy_router (
    .clk_rom    ( clk_rom   ),
    .rst        ( rst       ),
    .cfg        ( cfg       ),
    .db15_1     ( db15_1    ),
    .db15_2     ( db15_2    ),
    .usb_1      ( usb_1     ),
    .usb_2      ( usb_2     ),
    .usb_3      ( usb_3     ),
    .usb_4      ( usb_4     ),
    .player_1   ( player_1  ),
    .player_2   ( player_2  ),
    .player_3   ( player_3  ),
    .player_4   ( player_4  )
);

mister_ddr_arbiter u_ddr_arbiter (
    .clk_rom        ( clk_rom        ),
    .rst            ( rst            ),
    .downloading    ( downloading    ),
    .load_req       ( load_req       ),
    .load_busy      ( load_busy      ),
    .rot_req        ( rot_req        ),
    .rot_busy       ( rot_busy       ),
    .ddr_cmd        ( ddr_cmd        ),
    .ddr_busy       ( ddr_busy       ),
    .ddr_dout_ready ( ddr_dout_ready )
);

endmodule

// File: tests/mister_frame_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on the Wishbone handshake and the DDR command rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mister_frame_props import mister_cfg_pkg::*, mister_io_pkg::*; (
    input logic     clk_rom,
    input logic     rst,
    input wb_req_t  wb_req,
    input wb_rsp_t  wb_rsp,
    input ddr_cmd_t ddr_cmd,
    input logic     ddr_busy,
    input logic     load_busy,
    input logic     rot_busy
);

// Both requesters held off while the port is free only happens in a drain state
logic draining;
assign draining = load_busy & rot_busy & ~ddr_busy;

ack_follows_req: assert property (@(posedge clk_rom) disable iff (rst)
    wb_rsp.ack |-> $past(wb_req.cyc & wb_req.stb))
    else $error("Wishbone ack without a request in the previous cycle");

ack_single_cycle: assert property (@(posedge clk_rom) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("Wishbone ack high for two cycles in a row");

ddr_rd_we_exclusive: assert property (@(posedge clk_rom) disable iff (rst)
    !(ddr_cmd.rd && ddr_cmd.we))
    else $error("DDR read and write issued together");

ddr_no_rd_in_drain: assert property (@(posedge clk_rom) disable iff (rst)
    draining |-> !ddr_cmd.rd)
    else $error("DDR read issued during an ownership drain");

endmodule

bind mister_frame mister_frame_props u_props (
    .clk_rom   ( clk_rom   ),
    .rst       ( rst       ),
    .wb_req    ( wb_req    ),
    .wb_rsp    ( wb_rsp    ),
    .ddr_cmd   ( ddr_cmd   ),
    .ddr_busy  ( ddr_busy  ),
    .load_busy ( load_busy ),
    .rot_busy  ( rot_busy  )
);

// File: tests/tb_mister_frame.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the frame wrapper covering registers, joystick routing
// and DDR ownership hand-over
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_mister_frame import mister_cfg_pkg::*, mister_io_pkg::*; ();

localparam int BUTTONS  = 2;
localparam int WAIT_MAX = 40;

logic          clk_rom;
logic          rst;
wb_req_t       wb_req;
wb_rsp_t       wb_rsp;
logic [31:0]   status;
logic [31:0]   dipsw;
db15_word_t    db15_1;
db15_word_t    db15_2;
joy_word_t     usb_1;
joy_word_t     usb_2;
joy_word_t     usb_3;
joy_word_t     usb_4;
joy_word_t     player_1;
joy_word_t     player_2;
joy_word_t     player_3;
joy_word_t     player_4;
logic          downloading;
ddr_load_req_t load_req;
logic          load_busy;
ddr_rot_req_t  rot_req;
logic          rot_busy;
ddr_cmd_t      ddr_cmd;
logic          ddr_busy;
logic          ddr_dout_ready;

logic [31:0]   seed;
logic [31:0]   model_status;
logic [31:0]   model_dipsw;
int            errors;
int            tests;
int            test_errors;
int            beats;
ddr_rot_req_t  rv;
ddr_load_req_t lv;
ddr_cmd_t      exp_cmd;

mister_frame #(.BUTTONS(BUTTONS)) u_mister_frame (.*);

always #10 clk_rom = ~clk_rom;

function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

function automatic logic [31:0] reg_ref(logic [3:0] adr);
    logic [31:0] r;
    case (adr)
        4'd0:    r = model_status;
        4'd1:    r = model_dipsw;
        default: r = '0;
    endcase
    return r;
endfunction

// Directions and buttons, then start, then coin (start + button 2 counts too)
function automatic joy_word_t remap_ref(db15_word_t raw);
    joy_word_t w;
    w = joy_word_t'(raw) & joy_word_t'((1 << (4 + BUTTONS)) - 1);
    w[4+BUTTONS] = raw[10];
    w[5+BUTTONS] = raw[11] | (raw[10] & raw[5]);
    return w;
endfunction

function automatic joy_word_t route_ref(int n, logic en1, logic en2);
    joy_word_t usb [1:4];
    joy_word_t r;
    int        shift;
    usb   = '{usb_1, usb_2, usb_3, usb_4};
    shift = en1 ? 2 : (en2 ? 1 : 0);
    case (n)
        1:       r = en1 ? remap_ref(db15_1) : usb_1;
        2:       r = en2 ? remap_ref(db15_2) : usb[en1 ? 1 : 2];
        default: r = usb[n - shift];
    endcase
    return r;
endfunction

task automatic mismatch(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
endtask

task automatic check_joy(string name, joy_word_t got, joy_word_t exp);
    if (got !== exp) begin
        mismatch(name, 64'(got), 64'(exp));
    end
endtask

task automatic check_rsp(string name, wb_rsp_t got, logic [WB_DAT_W-1:0] exp);
    if (got.dat !== exp) begin
        mismatch(name, 64'(got.dat), 64'(exp));
    end
endtask

task automatic check_word(string name, logic [WB_DAT_W-1:0] got, logic [WB_DAT_W-1:0] exp);
    if (got !== exp) begin
        mismatch(name, 64'(got), 64'(exp));
    end
endtask

task automatic check_cmd(string name, ddr_cmd_t got, ddr_cmd_t exp);
    if (got !== exp) begin
        mismatch(name, 64'(got), 64'(exp));
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        mismatch(name, 64'(got), 64'(exp));
    end
endtask

task automatic finish_run();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
endtask

task automatic timeout(string what);
    errors++;
    $display("Timeout: no %s within %0d cycles", what, WAIT_MAX);
    finish_run();
endtask

task automatic end_test(string name);
    tests++;
    $display("%s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
endtask

// Request held until ack and dropped on the next rising edge
task automatic wb_access(input logic we, input logic [3:0] adr,
                         input logic [31:0] dat, output wb_rsp_t rsp);
    int n;
    n   = 0;
    rsp = '0;
    @(posedge clk_rom);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    while (rsp.ack !== 1'b1) begin
        @(negedge clk_rom);
        rsp = wb_rsp;
        n++;
        if (n > WAIT_MAX) begin
            timeout("Wishbone ack");
        end
    end
    @(posedge clk_rom);
    wb_req <= '0;
endtask

task automatic write_reg(logic [3:0] adr, logic [31:0] dat);
    wb_rsp_t rsp;
    wb_access(1'b1, adr, dat, rsp);
    case (adr)
        4'd0:    model_status = dat;
        4'd1:    model_dipsw  = dat;
        default: ;
    endcase
endtask

task automatic read_check(logic [3:0] adr);
    wb_rsp_t rsp;
    wb_access(1'b0, adr, rand32(), rsp);
    check_rsp($sformatf("wb_rsp.dat at address %0d", adr), rsp, reg_ref(adr));
endtask

task automatic set_enables(logic en1, logic en2);
    logic [31:0] v;
    v = rand32();
    v[STATUS_DB15_EN1_BIT] = en1;
    v[STATUS_DB15_EN2_BIT] = en2;
    write_reg(CFG_STATUS, v);
endtask

// New pads on one edge and registered players checked after the next
task automatic run_routing(int count, logic en1, logic en2);
    repeat (count) begin
        @(posedge clk_rom);
        db15_1 <= db15_word_t'(rand32());
        db15_2 <= db15_word_t'(rand32());
        usb_1  <= joy_word_t'(rand32());
        usb_2  <= joy_word_t'(rand32());
        usb_3  <= joy_word_t'(rand32());
        usb_4  <= joy_word_t'(rand32());
        @(posedge clk_rom);
        @(negedge clk_rom);
        check_joy("player_1", player_1, route_ref(1, en1, en2));
        check_joy("player_2", player_2, route_ref(2, en1, en2));
        check_joy("player_3", player_3, route_ref(3, en1, en2));
        check_joy("player_4", player_4, route_ref(4, en1, en2));
    end
endtask

// One beat per cycle while both requesters stay locked out
task automatic return_beats(int count);
    repeat (count) begin
        @(posedge clk_rom);
        ddr_dout_ready <= 1'b1;
        @(negedge clk_rom);
        check_bit("load_busy", load_busy, 1'b1);
        check_bit("rot_busy", rot_busy, 1'b1);
    end
    @(posedge clk_rom);
    ddr_dout_ready <= 1'b0;
endtask

task automatic wait_owner(logic to_load);
    int n;
    n = 0;
    @(negedge clk_rom);
    while ((to_load ? load_busy : rot_busy) !== 1'b0) begin
        n++;
        if (n > WAIT_MAX) begin
            timeout(to_load ? "loader ownership" : "rotator ownership");
        end
        @(negedge clk_rom);
    end
endtask

initial begin
    clk_rom        = 1'b0;
    rst            = 1'b1;
    wb_req         = '0;
    db15_1         = '0;
    db15_2         = '0;
    usb_1          = '0;
    usb_2          = '0;
    usb_3          = '0;
    usb_4          = '0;
    downloading    = 1'b0;
    load_req       = '0;
    rot_req        = '0;
    ddr_busy       = 1'b0;
    ddr_dout_ready = 1'b0;
    seed           = 32'ha593;
    model_status   = '0;
    model_dipsw    = '0;
    errors         = 0;
    tests          = 0;
    test_errors    = 0;
    repeat (4) @(posedge clk_rom);
    rst <= 1'b0;

    for (int i = 0; i < 4; i++) begin
        write_reg(CFG_STATUS, rand32());
        write_reg(CFG_DIPSW, rand32());
        read_check(CFG_STATUS);
        read_check(CFG_DIPSW);
        check_word("status", status, model_status);
        check_word("dipsw", dipsw, model_dipsw);
    end
    write_reg(4'd7, rand32());
    read_check(4'd7);
    read_check(CFG_STATUS);
    read_check(CFG_DIPSW);
    end_test("register access");

    set_enables(1'b0, 1'b0);
    run_routing(8, 1'b0, 1'b0);
    end_test("usb routing");

    for (int m = 0; m < 4; m++) begin
        set_enables(m[0], m[1]);
        run_routing(8, m[0], m[1]);
    end
    end_test("db15 routing");

    // Rotator write passes through and then a read is held off by ddr_busy
    // The loader keeps asking meanwhile and must stay off the port
    lv    = ddr_load_req_t'({rand32(), rand32()});
    lv.rd = 1'b1;
    rv    = ddr_rot_req_t'({rand32(), rand32()});
    rv.rd = 1'b0;
    rv.we = 1'b1;
    @(posedge clk_rom);
    rot_req  <= rv;
    load_req <= lv;
    @(negedge clk_rom);
    check_cmd("ddr_cmd", ddr_cmd, ddr_cmd_t'(rv));
    check_bit("load_busy", load_busy, 1'b1);
    check_bit("rot_busy", rot_busy, 1'b0);
    rv.rd = 1'b1;
    rv.we = 1'b0;
    @(posedge clk_rom);
    rot_req  <= rv;
    ddr_busy <= 1'b1;
    @(negedge clk_rom);
    check_cmd("ddr_cmd", ddr_cmd, ddr_cmd_t'(rv));
    check_bit("rot_busy", rot_busy, 1'b1);
    @(posedge clk_rom);
    rot_req  <= '0;
    load_req <= '0;
    ddr_busy <= 1'b0;
    end_test("rotator ownership");

    // Rotator read in flight when the download starts
    beats       = int'(rand32() % 8) + 1;
    rv          = ddr_rot_req_t'({rand32(), rand32()});
    rv.burstcnt = 8'(beats);
    rv.rd       = 1'b1;
    rv.we       = 1'b0;
    @(posedge clk_rom);
    rot_req <= rv;
    @(posedge clk_rom);
    rot_req     <= '0;
    downloading <= 1'b1;
    return_beats(beats);
    wait_owner(1'b1);

    // The rotator now asks for a write that must not reach the port
    lv          = ddr_load_req_t'({rand32(), rand32()});
    lv.burstcnt = 8'(int'(rand32() % 8) + 1);
    lv.rd       = 1'b1;
    rv          = ddr_rot_req_t'({rand32(), rand32()});
    rv.rd       = 1'b0;
    rv.we       = 1'b1;
    exp_cmd     = '{burstcnt: lv.burstcnt, addr: lv.addr, rd: 1'b1, we: 1'b0, be: '0};
    @(posedge clk_rom);
    load_req <= lv;
    rot_req  <= rv;
    @(negedge clk_rom);
    check_cmd("ddr_cmd", ddr_cmd, exp_cmd);
    check_bit("rot_busy", rot_busy, 1'b1);
    @(posedge clk_rom);
    load_req    <= '0;
    rot_req     <= '0;
    downloading <= 1'b0;
    return_beats(int'(lv.burstcnt));
    wait_owner(1'b0);
    check_bit("load_busy", load_busy, 1'b1);
    end_test("ddr handover");

    finish_run();
end

endmodule

// File: src.f
verilog/mister_cfg_pkg.sv
verilog/mister_io_pkg.sv
verilog/mister_cfg_regs.sv
verilog/mister_joy_router.sv
verilog/mister_ddr_arbiter.sv
verilog/mister_frame.sv
tests/mister_frame_props.sv
tests/tb_mister_frame.sv

// File: Makefile
# Verilator simulation of the frame wrapper

VERILATOR ?= verilator
TOP       ?= tb_mister_frame
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
